// ==== verilog.f ====
input_pkg.sv
reset_pkg.sv
joy_bus_if.sv
joy_4way.sv
joy_front.sv
joy_mapper.sv
board_ctrl.sv
input_board.sv
tb_input_board.sv

// ==== tb_input_board.sv ====
`timescale 1ns/1ps

module tb_input_board import input_pkg::*, reset_pkg::*; ();

    // several times the length of all tests together
    localparam int MAX_CYCLES = 6000;

    logic         clk_sys;
    logic         rst;
    logic         rst_req;
    logic         downloading;
    logic         en_4way;
    logic         rot_control;
    logic         dip_flip;
    logic         osd_pause;
    logic         key_pause;
    logic         key_reset;
    logic         key_service;
    dir_t         key_gfx;
    board_joy_t   board_joystick1;
    board_joy_t   board_joystick2;
    board_joy_t   board_joystick3;
    board_joy_t   board_joystick4;
    game_joy_t    key_joy1;
    game_joy_t    key_joy2;
    game_joy_t    key_joy3;
    player_bits_t key_coin;
    player_bits_t key_start;
    game_joy_t    game_joystick1;
    game_joy_t    game_joystick2;
    game_joy_t    game_joystick3;
    game_joy_t    game_joystick4;
    player_bits_t game_coin;
    player_bits_t game_start;
    logic         game_service;
    logic         game_pause;
    logic         game_rst;
    dir_t         gfx_en;

    // reference model state
    dir_t         held_dir [N_PLAYERS];
    board_joy_t   stage1   [N_PLAYERS];
    board_joy_t   stage2   [N_PLAYERS];
    game_joy_t    exp_joy  [N_PLAYERS];
    player_bits_t exp_coin;
    player_bits_t exp_start;
    logic         model_ready = 1'b0;
    int           errors = 0;
    int           cycles = 0;

    input_board dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    task automatic report_err(string name, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
    endtask

    task automatic check_joy(string name, game_joy_t exp, game_joy_t act);
        if (act !== exp)
            report_err(name, exp, act);
    endtask

    task automatic check_bits(string name, player_bits_t exp, player_bits_t act);
        if (act !== exp)
            report_err(name, exp, act);
    endtask

    task automatic check_dir(string name, dir_t exp, dir_t act);
        if (act !== exp)
            report_err(name, exp, act);
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp)
            report_err(name, exp, act);
    endtask

    // a lone direction is remembered and a diagonal keeps it while still held
    function automatic dir_t filter_dir(int p, dir_t din, logic en);
        if (!en)
            return din;
        if ($countones(din) == 1)
            held_dir[p] = din;
        return ((din & held_dir[p]) != '0) ? held_dir[p] : '0;
    endfunction

    function automatic game_joy_t expected_joy(game_joy_t raw, logic rot, logic flip);
        game_joy_t j;
        j = raw;
        // up, down, left, right take left, right, down, up (right, left, up, down flipped)
        if (rot) begin
            j[3] = flip ? raw[0] : raw[1];
            j[2] = flip ? raw[1] : raw[0];
            j[1] = flip ? raw[3] : raw[2];
            j[0] = flip ? raw[2] : raw[3];
        end
        return j ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
    endfunction

    function automatic player_bits_t expected_bits(player_bits_t joys, player_bits_t keys);
        return (joys | keys) ^ {N_PLAYERS{INPUTS_ACTIVE_LOW}};
    endfunction

    // expected outputs, board words go through two stages before the mapper
    always @(posedge clk_sys) begin
        board_joy_t   board_in [N_PLAYERS];
        game_joy_t    key_in   [N_PLAYERS];
        player_bits_t coins;
        player_bits_t starts;
        board_in = '{board_joystick1, board_joystick2, board_joystick3, board_joystick4};
        key_in   = '{key_joy1, key_joy2, key_joy3, '0};
        for (int p = 0; p < N_PLAYERS; p++) begin
            exp_joy[p] = expected_joy(stage2[p][GAME_JOY_W-1:0] | key_in[p],
                                      rot_control, dip_flip);
            coins[p]   = stage2[p][COIN_BIT];
            starts[p]  = stage2[p][START_BIT];
            stage2[p]  = stage1[p];
            stage1[p]  = {board_in[p][JOY_W-1:DIR_W],
                          filter_dir(p, board_in[p][DIR_W-1:0], en_4way)};
        end
        exp_coin  = expected_bits(coins, key_coin);
        exp_start = expected_bits(starts, key_start);
        if (rst) begin
            for (int p = 0; p < N_PLAYERS; p++) begin
                held_dir[p] = '0;
                stage1[p]   = '0;
                stage2[p]   = '0;
                exp_joy[p]  = '1;
            end
            exp_coin    = '1;
            exp_start   = '1;
            model_ready = 1'b1;
        end
    end

    always @(negedge clk_sys) begin
        if (model_ready) begin
            check_joy("game_joystick1", exp_joy[0], game_joystick1);
            check_joy("game_joystick2", exp_joy[1], game_joystick2);
            check_joy("game_joystick3", exp_joy[2], game_joystick3);
            check_joy("game_joystick4", exp_joy[3], game_joystick4);
            check_bits("game_coin", exp_coin, game_coin);
            check_bits("game_start", exp_start, game_start);
        end
    end

    task automatic next_cycle(int n = 1);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic clear_joys();
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_joystick3 = '0;
        board_joystick4 = '0;
        key_joy1        = '0;
        key_joy2        = '0;
        key_joy3        = '0;
        key_coin        = '0;
        key_start       = '0;
    endtask

    task automatic wait_pause(logic want, int max_cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk_sys);
            n++;
        end while (game_pause !== want && n <= max_cycles);
        check_flag("game_pause", want, game_pause);
    endtask

    task automatic tap_pause(logic want);
        key_pause = 1'b1;
        wait_pause(want, 2);
        next_cycle();
        key_pause = 1'b0;
        next_cycle(2);
    endtask

    task automatic check_rst_stretch(int rise_cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk_sys);
            n++;
        end while (game_rst !== 1'b1 && n <= rise_cycles);
        if (game_rst !== 1'b1) begin
            errors++;
            $display("game_rst did not rise after its trigger at %0t", $time);
        end else begin
            // first high sample already seen
            for (int i = 0; i < GAME_RST_LEN; i++) begin
                @(negedge clk_sys);
                check_flag("game_rst", 1'b1, game_rst);
            end
            @(negedge clk_sys);
            check_flag("game_rst", 1'b0, game_rst);
        end
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        dir_t want_gfx;
        rst         = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        en_4way     = 1'b0;
        rot_control = 1'b0;
        dip_flip    = 1'b0;
        osd_pause   = 1'b0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        clear_joys();
        void'($urandom(20));
        next_cycle(3);
        rst = 1'b0;
        check_flag("game_pause", 1'b0, game_pause);
        check_flag("game_service", INPUTS_ACTIVE_LOW, game_service);
        check_dir("gfx_en", '1, gfx_en);
        check_bits("game_coin", '1, game_coin);
        check_rst_stretch(0);
        next_cycle();

        // 50-cycle blocks, the last 15 cycles of each change only the keys
        for (int blk = 0; blk < 12; blk++) begin
            en_4way     = 1'($urandom() % 2);
            rot_control = 1'($urandom() % 2);
            dip_flip    = 1'($urandom() % 2);
            for (int c = 0; c < 50; c++) begin
                if (c < 35) begin
                    board_joystick1 = board_joy_t'($urandom());
                    board_joystick2 = board_joy_t'($urandom());
                    board_joystick3 = board_joy_t'($urandom());
                    board_joystick4 = board_joy_t'($urandom());
                end
                key_joy1  = game_joy_t'($urandom() & $urandom());
                key_joy2  = game_joy_t'($urandom() & $urandom());
                key_joy3  = game_joy_t'($urandom() & $urandom());
                key_coin  = player_bits_t'($urandom() & $urandom());
                key_start = player_bits_t'($urandom() & $urandom());
                next_cycle();
            end
        end
        clear_joys();
        en_4way     = 1'b0;
        rot_control = 1'b0;
        dip_flip    = 1'b0;
        next_cycle(5);

        // clear whatever pause the random joysticks left
        downloading = 1'b1;
        next_cycle();
        downloading = 1'b0;
        next_cycle();
        check_flag("game_pause", 1'b0, game_pause);
        osd_pause = 1'b1;
        wait_pause(1'b1, 2);
        next_cycle();
        tap_pause(1'b0);
        // menu change and key press together, menu value wins
        osd_pause = 1'b0;
        key_pause = 1'b1;
        repeat (4) begin
            @(negedge clk_sys);
            check_flag("game_pause", 1'b0, game_pause);
        end
        next_cycle();
        key_pause = 1'b0;
        next_cycle(2);
        board_joystick2[PAUSE_BIT] = 1'b1;
        wait_pause(1'b1, 4);
        next_cycle();
        board_joystick2 = '0;
        next_cycle(4);

        downloading = 1'b1;
        wait_pause(1'b0, 1);
        next_cycle();
        key_pause = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_sys);
            check_flag("game_pause", 1'b0, game_pause);
            check_flag("game_rst", 1'b1, game_rst);
        end
        next_cycle();
        key_pause   = 1'b0;
        downloading = 1'b0;
        check_rst_stretch(0);
        next_cycle(2);

        // soft reset key first, then the reset request
        for (int src = 0; src < 2; src++) begin
            key_reset = (src == 0);
            rst_req   = (src == 1);
            fork
                begin
                    next_cycle();
                    key_reset = 1'b0;
                    rst_req   = 1'b0;
                end
                check_rst_stretch(src == 0 ? 3 : 1);
            join
            next_cycle(2);
        end

        // all layers enabled since reset
        want_gfx = '1;
        for (int b = 0; b < DIR_W; b++) begin
            want_gfx = want_gfx ^ dir_t'(1 << b);
            key_gfx  = dir_t'(1 << b);
            next_cycle(3);
            key_gfx = '0;
            next_cycle(3);
            check_dir("gfx_en", want_gfx, gfx_en);
        end

        key_service = 1'b1;
        next_cycle();
        check_flag("game_service", ~INPUTS_ACTIVE_LOW, game_service);
        key_service = 1'b0;
        next_cycle();
        check_flag("game_service", INPUTS_ACTIVE_LOW, game_service);

        next_cycle(4);
        $display("run finished with %0d errors", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== input_board.sv ====
`timescale 1ns/1ps

module input_board import input_pkg::*; (
    input  logic         clk_sys,
    input  logic         rst,
    input  logic         rst_req,
    input  logic         downloading,
    input  logic         en_4way,
    input  logic         rot_control,
    input  logic         dip_flip,
    input  logic         osd_pause,
    input  logic         key_pause,
    input  logic         key_reset,
    input  logic         key_service,
    input  dir_t         key_gfx,
    input  board_joy_t   board_joystick1,
    input  board_joy_t   board_joystick2,
    input  board_joy_t   board_joystick3,
    input  board_joy_t   board_joystick4,
    input  game_joy_t    key_joy1,
    input  game_joy_t    key_joy2,
    input  game_joy_t    key_joy3,
    input  player_bits_t key_coin,
    input  player_bits_t key_start,
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output game_joy_t    game_joystick3,
    output game_joy_t    game_joystick4,
    output player_bits_t game_coin,
    output player_bits_t game_start,
    output logic         game_service,
    output logic         game_pause,
    output logic         game_rst,
    output dir_t         gfx_en
);

    // registered board joysticks
    joy_bus_if joys ();

    joy_front u_front (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .en_4way    (en_4way),
        .board_joy1 (board_joystick1),
        .board_joy2 (board_joystick2),
        .board_joy3 (board_joystick3),
        .board_joy4 (board_joystick4),
        .joys       (joys.front)
    );

    joy_mapper u_mapper (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rot_control (rot_control),
        .dip_flip    (dip_flip),
        .joys        (joys.mapper),
        .key_joy1    (key_joy1),
        .key_joy2    (key_joy2),
        .key_joy3    (key_joy3),
        .key_coin    (key_coin),
        .key_start   (key_start),
        .game_joy1   (game_joystick1),
        .game_joy2   (game_joystick2),
        .game_joy3   (game_joystick3),
        .game_joy4   (game_joystick4),
        .game_coin   (game_coin),
        .game_start  (game_start)
    );

    board_ctrl u_ctrl (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .rst_req      (rst_req),
        .downloading  (downloading),
        .osd_pause    (osd_pause),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .key_service  (key_service),
        .key_gfx      (key_gfx),
        .joys         (joys.ctrl),
        .game_pause   (game_pause),
        .game_service (game_service),
        .game_rst     (game_rst),
        .gfx_en       (gfx_en)
    );

endmodule

// ==== board_ctrl.sv ====
`timescale 1ns/1ps

module board_ctrl import input_pkg::*, reset_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst,
    input  logic  rst_req,
    input  logic  downloading,
    input  logic  osd_pause,
    input  logic  key_pause,
    input  logic  key_reset,
    input  logic  key_service,
    input  dir_t  key_gfx,
    joy_bus_if.ctrl joys,
    output logic  game_pause,
    output logic  game_service,
    output logic  game_rst,
    output dir_t  gfx_en
);

    typedef struct packed {
        dir_t gfx;
        logic joy_pause;
        logic reset;
        logic pause;
    } edge_in_t;

    edge_in_t edge_now;
    edge_in_t edge_d;
    edge_in_t edge_dd;
    edge_in_t edge_rise;
    logic     osd_d;
    logic     osd_dd;
    logic     soft_rst;
    logic     rst_trig;
    rst_cnt_t rst_cnt;

    assign edge_now = '{
        gfx:       key_gfx,
        joy_pause: joys.joy1[PAUSE_BIT] | joys.joy2[PAUSE_BIT],
        reset:     key_reset,
        pause:     key_pause
    };

    // rising edges one stage after sampling
    assign edge_rise = edge_d & ~edge_dd;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            edge_d       <= '0;
            edge_dd      <= '0;
            osd_d        <= 1'b0;
            osd_dd       <= 1'b0;
            game_pause   <= 1'b0;
            game_service <= INPUTS_ACTIVE_LOW;
            soft_rst     <= 1'b0;
            gfx_en       <= '1;
        end else begin
            edge_d       <= edge_now;
            edge_dd      <= edge_d;
            osd_d        <= osd_pause;
            osd_dd       <= osd_d;
            game_service <= key_service ^ INPUTS_ACTIVE_LOW;
            soft_rst     <= edge_rise.reset;
            gfx_en       <= gfx_en ^ edge_rise.gfx;

            // a change in the menu setting wins over a toggle
            if (downloading)
                game_pause <= 1'b0;
            else if (osd_d != osd_dd)
                game_pause <= osd_d;
            else if (edge_rise.pause || edge_rise.joy_pause)
                game_pause <= ~game_pause;
        end
    end

    assign rst_trig = rst | rst_req | downloading | soft_rst;

    // game reset held GAME_RST_LEN cycles past the last trigger
    always_ff @(posedge clk_sys) begin
        if (rst_trig) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt < GAME_RST_LEN) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst
    );

    a_rst_stretch: assert property (
        @(posedge clk_sys) disable iff (rst)
        (rst_cnt < GAME_RST_LEN) |-> game_rst
    );

endmodule

// ==== joy_mapper.sv ====
`timescale 1ns/1ps

module joy_mapper import input_pkg::*; (
    input  logic         clk_sys,
    input  logic         rst,
    input  logic         rot_control,
    input  logic         dip_flip,
    joy_bus_if.mapper    joys,
    input  game_joy_t    key_joy1,
    input  game_joy_t    key_joy2,
    input  game_joy_t    key_joy3,
    input  player_bits_t key_coin,
    input  player_bits_t key_start,
    output game_joy_t    game_joy1,
    output game_joy_t    game_joy2,
    output game_joy_t    game_joy3,
    output game_joy_t    game_joy4,
    output player_bits_t game_coin,
    output player_bits_t game_start
);

    // rotation for vertical games, then polarity
    function automatic game_joy_t map_joy(game_joy_t joy_in, logic rot, logic flip);
        game_joy_t joy_rot;
        joy_rot = joy_in;
        if (rot) begin
            if (flip)
                joy_rot[DIR_W-1:0] = {joy_in[0], joy_in[1], joy_in[3], joy_in[2]};
            else
                joy_rot[DIR_W-1:0] = {joy_in[1], joy_in[0], joy_in[2], joy_in[3]};
        end
        return joy_rot ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
    endfunction

    player_bits_t coin_all;
    player_bits_t start_all;

    always_comb begin
        coin_all  = {joys.joy4[COIN_BIT], joys.joy3[COIN_BIT],
                     joys.joy2[COIN_BIT], joys.joy1[COIN_BIT]} | key_coin;
        start_all = {joys.joy4[START_BIT], joys.joy3[START_BIT],
                     joys.joy2[START_BIT], joys.joy1[START_BIT]} | key_start;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            // idle means nothing pressed
            game_joy1  <= {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_joy2  <= {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_joy3  <= {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_joy4  <= {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_coin  <= {N_PLAYERS{INPUTS_ACTIVE_LOW}};
            game_start <= {N_PLAYERS{INPUTS_ACTIVE_LOW}};
        end else begin
            game_joy1  <= map_joy(joys.joy1[GAME_JOY_W-1:0] | key_joy1, rot_control, dip_flip);
            game_joy2  <= map_joy(joys.joy2[GAME_JOY_W-1:0] | key_joy2, rot_control, dip_flip);
            game_joy3  <= map_joy(joys.joy3[GAME_JOY_W-1:0] | key_joy3, rot_control, dip_flip);
            // no keyboard mapping for player 4
            game_joy4  <= map_joy(joys.joy4[GAME_JOY_W-1:0], rot_control, dip_flip);
            game_coin  <= coin_all ^ {N_PLAYERS{INPUTS_ACTIVE_LOW}};
            game_start <= start_all ^ {N_PLAYERS{INPUTS_ACTIVE_LOW}};
        end
    end

    a_no_x: assert property (
        @(posedge clk_sys) disable iff (rst)
        !$isunknown({game_joy1, game_joy2, game_joy3, game_joy4, game_coin, game_start})
    );

endmodule

// ==== joy_front.sv ====
`timescale 1ns/1ps

module joy_front import input_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       en_4way,
    input  board_joy_t board_joy1,
    input  board_joy_t board_joy2,
    input  board_joy_t board_joy3,
    input  board_joy_t board_joy4,
    joy_bus_if.front   joys
);

    board_joy_t joy_in  [N_PLAYERS];
    board_joy_t joy_out [N_PLAYERS];

    assign joy_in = '{board_joy1, board_joy2, board_joy3, board_joy4};

    for (genvar p = 0; p < N_PLAYERS; p++) begin : g_player
        dir_t                 dir_4way;
        dir_t                 dir_d;
        logic [JOY_W-1:DIR_W] btn_d1;
        logic [JOY_W-1:DIR_W] btn_d2;

        joy_4way u_4way (
            .clk_sys (clk_sys),
            .rst     (rst),
            .en_4way (en_4way),
            .dir_in  (joy_in[p][DIR_W-1:0]),
            .dir_out (dir_4way)
        );

        // buttons get two stages so they line up with the filtered directions
        always_ff @(posedge clk_sys) begin
            if (rst) begin
                dir_d  <= '0;
                btn_d1 <= '0;
                btn_d2 <= '0;
            end else begin
                dir_d  <= dir_4way;
                btn_d1 <= joy_in[p][JOY_W-1:DIR_W];
                btn_d2 <= btn_d1;
            end
        end

        assign joy_out[p] = {btn_d2, dir_d};
    end

    assign joys.joy1 = joy_out[0];
    assign joys.joy2 = joy_out[1];
    assign joys.joy3 = joy_out[2];
    assign joys.joy4 = joy_out[3];

endmodule

// ==== joy_4way.sv ====
`timescale 1ns/1ps

module joy_4way import input_pkg::*; (
    input  logic clk_sys,
    input  logic rst,
    input  logic en_4way,
    input  dir_t dir_in,
    output dir_t dir_out
);

    // last single direction seen while filtering
    dir_t last_dir;
    logic single;
    logic last_held;

    always_comb begin
        single    = $onehot(dir_in);
        last_held = |(dir_in & last_dir);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out  <= '0;
            last_dir <= '0;
        end else if (!en_4way) begin
            dir_out <= dir_in;
        end else if (single) begin
            dir_out  <= dir_in;
            last_dir <= dir_in;
        end else if (last_held) begin
            // diagonal keeps the direction that was pressed first
            dir_out <= last_dir;
        end else begin
            dir_out <= '0;
        end
    end

    // filtered output never shows a diagonal
    a_one_dir: assert property (
        @(posedge clk_sys) disable iff (rst)
        en_4way |=> $countones(dir_out) <= 1
    );

endmodule

// ==== joy_bus_if.sv ====
`timescale 1ns/1ps

interface joy_bus_if import input_pkg::*; ();

    board_joy_t joy1;
    board_joy_t joy2;
    board_joy_t joy3;
    board_joy_t joy4;

    modport front (
        output joy1, joy2, joy3, joy4
    );

    modport mapper (
        input joy1, joy2, joy3, joy4
    );

    // pause only comes from the first two players
    modport ctrl (
        input joy1, joy2
    );

endinterface

// ==== reset_pkg.sv ====
package reset_pkg;

    // cycles game_rst is held after the last trigger
    localparam int GAME_RST_LEN = 32;

    // must reach GAME_RST_LEN and saturate there
    typedef logic [$clog2(GAME_RST_LEN+1)-1:0] rst_cnt_t;

endpackage

// ==== input_pkg.sv ====
package input_pkg;

    // board side joystick word
    localparam int JOY_W      = 16;
    // game side joystick
    localparam int GAME_JOY_W = 10;
    // direction field, bit 0 right, 1 left, 2 down, 3 up
    localparam int DIR_W      = 4;
    localparam int N_PLAYERS  = 4;
    localparam int BUTTONS    = 2;

    // start, coin and pause sit right above the game buttons
    localparam int START_BIT  = 6 + (BUTTONS - 2);
    localparam int COIN_BIT   = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT  = 8 + (BUTTONS - 2);

    // game inputs are active low on most boards
    localparam logic INPUTS_ACTIVE_LOW = 1'b1;

    typedef logic [JOY_W-1:0]      board_joy_t;
    typedef logic [GAME_JOY_W-1:0] game_joy_t;
    typedef logic [DIR_W-1:0]      dir_t;
    typedef logic [N_PLAYERS-1:0]  player_bits_t;

endpackage
